//--- sharedFifoTop.f
design/fifoCfgPkg.sv
design/fifoTypesPkg.sv
design/sharedRam.sv
design/rrArbiter.sv
design/linkedListMgr.sv
design/popStager.sv
design/sharedFifoCtrl.sv
design/sharedFifoTop.sv
verification/sharedFifoTb.sv

//--- Makefile
TOOL       := verilator
TOP        := sharedFifoTb
RTL_TOP    := sharedFifoTop
FILELIST   := sharedFifoTop.f
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/sharedFifoTb.sv
// ----------------------------------------------------------------------
// Shared multi-FIFO testbench
// Random pushes and pops checked against per-FIFO queue models
// ----------------------------------------------------------------------

module sharedFifoTb;
  timeunit 1ns;
  timeprecision 1ps;
  import fifoCfgPkg::*;
  import fifoTypesPkg::*;

  localparam int NumPushes = 2000;
  localparam int ClkPeriod = 10;
  // Budget of 20 cycles per push
  localparam int TimeoutNs = NumPushes * 20 * ClkPeriod;

  logic clk;
  logic rst;
  logic pushValid;
  logic pushReady;
  pushReqT pushReq;
  logic pushFull;
  logic [NumFifos-1:0] popValid;
  logic [NumFifos-1:0] popReady;
  dataT [NumFifos-1:0] popData;
  logic [NumFifos-1:0] popEmpty;

  int seed = 26235;
  int sent;

  // Expected contents of each logical FIFO including staged items
  dataT modelQ [NumFifos][$];

  // Handshakes seen before a rising edge are applied to the model on that edge
  logic pushSeen;
  pushReqT pushSeenReq;
  logic [NumFifos-1:0] popSeen;

  // Pop port state from one cycle back feeds the hold check
  logic [NumFifos-1:0] prevValid;
  logic [NumFifos-1:0] prevReady;
  dataT [NumFifos-1:0] prevData;

  sharedFifoTop u_dut (
    .clk,
    .rst,
    .pushValid,
    .pushReady,
    .pushReq,
    .pushFull,
    .popValid,
    .popReady,
    .popData,
    .popEmpty
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(TimeoutNs);
    $display("Watchdog: test timed out after %0d ns without finishing", TimeoutNs);
    $display("TEST FAIL");
    $fatal(1, "Timeout");
  end

  task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0t: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      $display("TEST FAIL");
      $fatal(1, "Mismatch in %s", what);
    end
  endtask

  function automatic int modelItems();
    int total;
    total = 0;
    for (int f = 0; f < NumFifos; f++) begin
      total += modelQ[f].size();
    end
    return total;
  endfunction

  // An entry is free again once its data sits in a staging slot
  function automatic int modelFreeEntries();
    return Depth - modelItems() + $countones(popValid);
  endfunction

  // A FIFO with items but an empty slot may have a data read on the way,
  // and that entry is already back on the freelist
  function automatic logic readMayBeInFlight();
    for (int f = 0; f < NumFifos; f++) begin
      if (!popValid[f] && (modelQ[f].size() != 0)) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // Monitor checks at the falling edge and updates the model at the rising edge
  initial begin
    pushSeen = 1'b0;
    pushSeenReq = '0;
    popSeen = '0;
    prevValid = '0;
    prevReady = '0;
    prevData = '0;
    forever begin
      @(negedge clk);
      if (rst) begin
        pushSeen = 1'b0;
        popSeen = '0;
        prevValid = '0;
      end else begin
        for (int f = 0; f < NumFifos; f++) begin
          checkEq(popEmpty[f], modelQ[f].size() == 0, $sformatf("popEmpty of FIFO %0d", f));
          // A stalled consumer sees the same item again
          if (prevValid[f] && !prevReady[f]) begin
            checkEq(popValid[f], 1'b1, $sformatf("held popValid of FIFO %0d", f));
            checkEq(popData[f], prevData[f], $sformatf("held popData of FIFO %0d", f));
          end
          if (popValid[f] && popReady[f]) begin
            checkEq(popData[f], modelQ[f][0], $sformatf("pop order of FIFO %0d", f));
          end
        end
        if (!readMayBeInFlight()) begin
          checkEq(pushFull, modelFreeEntries() == 0, "pushFull against model free count");
        end
        pushSeen = pushValid && pushReady;
        pushSeenReq = pushReq;
        popSeen = popValid & popReady;
        prevValid = popValid;
        prevReady = popReady;
        prevData = popData;
      end
      @(posedge clk);
      if (pushSeen) begin
        modelQ[pushSeenReq.fifoId].push_back(pushSeenReq.data);
      end
      for (int f = 0; f < NumFifos; f++) begin
        if (popSeen[f]) begin
          void'(modelQ[f].pop_front());
        end
      end
    end
  end

  // Stimulus is driven 1 ns after each rising edge
  initial begin
    rst = 1'b1;
    pushValid = 1'b0;
    pushReq = '0;
    popReady = '0;
    sent = 0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    while (sent < NumPushes) begin
      @(posedge clk);
      #1;
      if (pushValid && pushSeen) begin
        sent++;
      end
      // A refused push keeps its request until the edge that takes it
      if (!pushValid || pushSeen) begin
        pushValid = (sent < NumPushes) && (($random(seed) & 3) != 0);
        pushReq.fifoId = fifoIdT'($random(seed));
        pushReq.data = dataT'($random(seed));
      end
      // Slow consumers in alternate stretches so that storage fills up
      if (((sent / 200) % 2) == 1) begin
        popReady = NumFifos'($random(seed) & $random(seed) & $random(seed));
      end else begin
        popReady = NumFifos'($random(seed));
      end
    end

    // Drain every FIFO
    @(posedge clk);
    #1;
    popReady = '1;
    while (modelItems() != 0) begin
      @(negedge clk);
    end
    checkEq(popValid, '0, "popValid after drain");
    checkEq(popEmpty, {NumFifos{1'b1}}, "popEmpty after drain");
    checkEq(pushReady, 1'b1, "pushReady after drain");
    $display("TEST PASS");
    $finish;
  end

endmodule : sharedFifoTb

//--- design/sharedFifoTop.sv
// ----------------------------------------------------------------------
// Shared multi-FIFO top level
// Controller, data RAM, pointer RAM and the pop arbiter
// ----------------------------------------------------------------------

module sharedFifoTop (
  input  logic                                           clk,
  input  logic                                           rst,
  input  logic                                           pushValid,
  output logic                                           pushReady,
  input  fifoTypesPkg::pushReqT                          pushReq,
  output logic                                           pushFull,
  output logic [fifoCfgPkg::NumFifos-1:0]                popValid,
  input  logic [fifoCfgPkg::NumFifos-1:0]                popReady,
  output fifoTypesPkg::dataT [fifoCfgPkg::NumFifos-1:0]  popData,
  output logic [fifoCfgPkg::NumFifos-1:0]                popEmpty
);
  import fifoCfgPkg::*;
  import fifoTypesPkg::*;

  dataWrT dataWr;
  ptrWrT ptrWr;
  ramRdT dataRd;
  ramRdT ptrRd;
  dataT dataRdData;
  entryT ptrRdData;
  logic [NumFifos-1:0] arbRequest;
  logic [NumFifos-1:0] arbGrant;
  logic arbEnablePriorityUpdate;

  sharedFifoCtrl uCtrl (
    .clk,
    .rst,
    .pushValid,
    .pushReady,
    .pushReq,
    .pushFull,
    .popValid,
    .popReady,
    .popData,
    .popEmpty,
    .dataWr,
    .ptrWr,
    .ptrRd,
    .ptrRdData,
    .dataRd,
    .dataRdData,
    .arbRequest,
    .arbGrant,
    .arbEnablePriorityUpdate
  );

  // Payload storage
  sharedRam #(.payloadT(dataT)) uDataRam (
    .clk,
    .wr(dataWr),
    .rd(dataRd),
    .rdData(dataRdData)
  );

  // Next-entry links of every list
  sharedRam #(.payloadT(entryT)) uPtrRam (
    .clk,
    .wr(ptrWr),
    .rd(ptrRd),
    .rdData(ptrRdData)
  );

  rrArbiter uArb (
    .clk,
    .rst,
    .request(arbRequest),
    .grant(arbGrant),
    .enablePriorityUpdate(arbEnablePriorityUpdate)
  );

endmodule : sharedFifoTop

//--- design/sharedFifoCtrl.sv
// ----------------------------------------------------------------------
// Shared multi-FIFO controller
// Freelist and push allocation around the list manager and pop stager
// ----------------------------------------------------------------------

module sharedFifoCtrl (
  input  logic                                           clk,
  input  logic                                           rst,
  input  logic                                           pushValid,
  output logic                                           pushReady,
  input  fifoTypesPkg::pushReqT                          pushReq,
  output logic                                           pushFull,
  output logic [fifoCfgPkg::NumFifos-1:0]                popValid,
  input  logic [fifoCfgPkg::NumFifos-1:0]                popReady,
  output fifoTypesPkg::dataT [fifoCfgPkg::NumFifos-1:0]  popData,
  output logic [fifoCfgPkg::NumFifos-1:0]                popEmpty,
  output fifoTypesPkg::dataWrT                           dataWr,
  output fifoTypesPkg::ptrWrT                            ptrWr,
  output fifoTypesPkg::ramRdT                            ptrRd,
  input  fifoTypesPkg::entryT                            ptrRdData,
  output fifoTypesPkg::ramRdT                            dataRd,
  input  fifoTypesPkg::dataT                             dataRdData,
  output logic [fifoCfgPkg::NumFifos-1:0]                arbRequest,
  input  logic [fifoCfgPkg::NumFifos-1:0]                arbGrant,
  output logic                                           arbEnablePriorityUpdate
);
  import fifoCfgPkg::*;
  import fifoTypesPkg::*;

  // Circular queue of free entry IDs, pointers wrap since Depth is 2**AddrWidth
  entryT freeList [Depth];
  entryT freeRdPtr;
  entryT freeWrPtr;
  logic [CountWidth-1:0] freeCount;
  logic pushAccept;
  entryT allocEntry;

  logic deallocValid;
  entryT deallocEntry;
  logic [NumFifos-1:0] headValid;
  logic [NumFifos-1:0] headReady;
  entryT [NumFifos-1:0] head;
  logic [NumFifos-1:0][CountWidth-1:0] fifoCount;

  assign pushReady = freeCount != '0;
  assign pushFull = ~pushReady;
  assign pushAccept = pushValid && pushReady;
  assign allocEntry = freeList[freeRdPtr];

  // Payload goes straight to the allocated entry on the accept edge
  assign dataWr.valid = pushAccept;
  assign dataWr.addr = allocEntry;
  assign dataWr.data = pushReq.data;

  always_ff @(posedge clk) begin
    if (rst) begin
      freeRdPtr <= '0;
      freeWrPtr <= '0;
      freeCount <= CountWidth'(Depth);
      // Every entry starts out free
      for (int i = 0; i < Depth; i++) begin
        freeList[i] <= AddrWidth'(i);
      end
    end else begin
      if (pushAccept) begin
        freeRdPtr <= freeRdPtr + 1'b1;
      end
      if (deallocValid) begin
        freeList[freeWrPtr] <= deallocEntry;
        freeWrPtr <= freeWrPtr + 1'b1;
      end
      freeCount <= freeCount - CountWidth'(pushAccept) + CountWidth'(deallocValid);
    end
  end

  linkedListMgr uListMgr (
    .clk,
    .rst,
    .allocValid(pushAccept),
    .allocFifo(pushReq.fifoId),
    .allocEntry,
    .headValid,
    .head,
    .headReady,
    .fifoCount,
    .ptrWr,
    .ptrRd,
    .ptrRdData
  );

  popStager uStager (
    .clk,
    .rst,
    .headValid,
    .head,
    .headReady,
    .fifoCount,
    .dataRd,
    .dataRdData,
    .popValid,
    .popReady,
    .popData,
    .popEmpty,
    .deallocValid,
    .deallocEntry,
    .arbRequest,
    .arbGrant,
    .arbEnablePriorityUpdate
  );

  // Returns from the pop side can never overfill the pool
  freeCountBoundA : assert property (@(posedge clk) disable iff (rst)
    freeCount <= CountWidth'(Depth));

  // A stalled push keeps its request until it is taken or withdrawn
  pushReqStableA : assert property (@(posedge clk) disable iff (rst)
    pushValid && !pushReady |=> !pushValid || $stable(pushReq));

endmodule : sharedFifoCtrl

//--- design/popStager.sv
// ----------------------------------------------------------------------
// Pop stager
// One staging slot per FIFO, refilled from the data RAM via the arbiter
// ----------------------------------------------------------------------

module popStager (
  input  logic                                                        clk,
  input  logic                                                        rst,
  input  logic [fifoCfgPkg::NumFifos-1:0]                             headValid,
  input  fifoTypesPkg::entryT [fifoCfgPkg::NumFifos-1:0]              head,
  output logic [fifoCfgPkg::NumFifos-1:0]                             headReady,
  input  logic [fifoCfgPkg::NumFifos-1:0][fifoCfgPkg::CountWidth-1:0] fifoCount,
  output fifoTypesPkg::ramRdT                                         dataRd,
  input  fifoTypesPkg::dataT                                          dataRdData,
  output logic [fifoCfgPkg::NumFifos-1:0]                             popValid,
  input  logic [fifoCfgPkg::NumFifos-1:0]                             popReady,
  output fifoTypesPkg::dataT [fifoCfgPkg::NumFifos-1:0]               popData,
  output logic [fifoCfgPkg::NumFifos-1:0]                             popEmpty,
  output logic                                                        deallocValid,
  output fifoTypesPkg::entryT                                         deallocEntry,
  output logic [fifoCfgPkg::NumFifos-1:0]                             arbRequest,
  input  logic [fifoCfgPkg::NumFifos-1:0]                             arbGrant,
  output logic                                                        arbEnablePriorityUpdate
);
  import fifoCfgPkg::*;
  import fifoTypesPkg::*;

  logic [NumFifos-1:0] slotValid;
  // One-hot, marks the FIFO whose data RAM read lands this cycle
  logic [NumFifos-1:0] inFlight;
  dataT [NumFifos-1:0] slotData;
  fifoIdT grantFifo;

  always_comb begin
    grantFifo = '0;
    for (int f = 0; f < NumFifos; f++) begin
      if (arbGrant[f]) begin
        grantFifo = fifoIdT'(f);
      end
      popEmpty[f] = (fifoCount[f] == '0) && !inFlight[f] && !slotValid[f];
    end
  end

  // Only an empty slot with nothing on the way asks for a refill
  assign arbRequest = headValid & ~slotValid & ~inFlight;
  assign arbEnablePriorityUpdate = |arbGrant;
  assign headReady = arbGrant;

  // The grant edge reads the entry and frees it in the same cycle
  assign dataRd.valid = |arbGrant;
  assign dataRd.addr = head[grantFifo];
  assign deallocValid = |arbGrant;
  assign deallocEntry = head[grantFifo];

  assign popValid = slotValid;
  assign popData = slotData;

  always_ff @(posedge clk) begin
    if (rst) begin
      inFlight <= '0;
      slotValid <= '0;
    end else begin
      inFlight <= arbGrant;
      for (int f = 0; f < NumFifos; f++) begin
        if (inFlight[f]) begin
          slotValid[f] <= 1'b1;
        end else if (popReady[f]) begin
          slotValid[f] <= 1'b0;
        end
      end
    end
  end

  // Read data belongs to the FIFO granted one cycle earlier
  always_ff @(posedge clk) begin
    for (int f = 0; f < NumFifos; f++) begin
      if (inFlight[f]) begin
        slotData[f] <= dataRdData;
      end
    end
  end

  slotNoOverwriteA : assert property (@(posedge clk) disable iff (rst)
    (inFlight & slotValid) == '0);

endmodule : popStager

//--- design/linkedListMgr.sv
// ----------------------------------------------------------------------
// Linked-list manager
// Head, tail and count per FIFO, plus link writes and next-pointer reads
// ----------------------------------------------------------------------

module linkedListMgr (
  input  logic                                                        clk,
  input  logic                                                        rst,
  input  logic                                                        allocValid,
  input  fifoTypesPkg::fifoIdT                                        allocFifo,
  input  fifoTypesPkg::entryT                                         allocEntry,
  output logic [fifoCfgPkg::NumFifos-1:0]                             headValid,
  output fifoTypesPkg::entryT [fifoCfgPkg::NumFifos-1:0]              head,
  input  logic [fifoCfgPkg::NumFifos-1:0]                             headReady,
  output logic [fifoCfgPkg::NumFifos-1:0][fifoCfgPkg::CountWidth-1:0] fifoCount,
  output fifoTypesPkg::ptrWrT                                         ptrWr,
  output fifoTypesPkg::ramRdT                                         ptrRd,
  input  fifoTypesPkg::entryT                                         ptrRdData
);
  import fifoCfgPkg::*;
  import fifoTypesPkg::*;

  entryT [NumFifos-1:0] tail;
  // Next-pointer read issued last cycle, data arrives this cycle
  logic [NumFifos-1:0] pending;
  logic [NumFifos-1:0] pushHit;
  logic [NumFifos-1:0] hasNext;
  fifoIdT readFifo;

  always_comb begin
    pushHit = '0;
    pushHit[allocFifo] = allocValid;
    readFifo = '0;
    for (int f = 0; f < NumFifos; f++) begin
      hasNext[f] = fifoCount[f] > CountWidth'(1);
      if (headReady[f]) begin
        readFifo = fifoIdT'(f);
      end
    end
  end

  // Link from the old tail, written on the accept edge
  assign ptrWr.valid = allocValid && (fifoCount[allocFifo] != '0);
  assign ptrWr.addr = tail[allocFifo];
  assign ptrWr.next = allocEntry;

  // A last item has no link to follow
  assign ptrRd.valid = |(headReady & hasNext);
  assign ptrRd.addr = head[readFifo];

  always_ff @(posedge clk) begin
    if (rst) begin
      headValid <= '0;
      pending <= '0;
      fifoCount <= '0;
    end else begin
      for (int f = 0; f < NumFifos; f++) begin
        fifoCount[f] <= fifoCount[f] + CountWidth'(pushHit[f]) - CountWidth'(headReady[f]);
        if (headReady[f]) begin
          // Last item leaving, a push in the same cycle becomes the head
          headValid[f] <= hasNext[f] ? 1'b0 : pushHit[f];
          pending[f] <= hasNext[f];
        end else if (pending[f]) begin
          headValid[f] <= 1'b1;
          pending[f] <= 1'b0;
        end else if (pushHit[f] && (fifoCount[f] == '0)) begin
          headValid[f] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int f = 0; f < NumFifos; f++) begin
      if (pushHit[f]) begin
        tail[f] <= allocEntry;
      end
      if (pending[f]) begin
        head[f] <= ptrRdData;
      end else if (pushHit[f] && ((fifoCount[f] == '0) || (headReady[f] && !hasNext[f]))) begin
        head[f] <= allocEntry;
      end
    end
  end

  // The pop side only dequeues a head that this block has published
  headReadyLegalA : assert property (@(posedge clk) disable iff (rst)
    (headReady & ~headValid) == '0);

endmodule : linkedListMgr

//--- design/rrArbiter.sv
// ----------------------------------------------------------------------
// Round-robin arbiter
// Grants the first requester after the last winner
// ----------------------------------------------------------------------

module rrArbiter (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [fifoCfgPkg::NumFifos-1:0]  request,
  output logic [fifoCfgPkg::NumFifos-1:0]  grant,
  input  logic                             enablePriorityUpdate
);
  import fifoCfgPkg::*;

  logic [FifoIdWidth-1:0] lastWinner;
  logic [FifoIdWidth-1:0] winner;

  // Search starts one past the last winner and wraps around
  always_comb begin
    int idx;
    logic found;
    grant = '0;
    winner = lastWinner;
    found = 1'b0;
    for (int i = 1; i <= NumFifos; i++) begin
      idx = (int'(lastWinner) + i) % NumFifos;
      if (!found && request[idx]) begin
        grant[idx] = 1'b1;
        winner = FifoIdWidth'(idx);
        found = 1'b1;
      end
    end
  end

  // Reset value puts requester 0 first in line
  always_ff @(posedge clk) begin
    if (rst) begin
      lastWinner <= FifoIdWidth'(NumFifos - 1);
    end else if (enablePriorityUpdate && (|grant)) begin
      lastWinner <= winner;
    end
  end

  grantLegalA : assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant) && ((grant & ~request) == '0));

endmodule : rrArbiter

//--- design/sharedRam.sv
// ----------------------------------------------------------------------
// Shared RAM
// One write port and one read port with a registered read
// ----------------------------------------------------------------------

module sharedRam #(
  parameter type payloadT = fifoTypesPkg::dataT,
  // Write port layout, bit compatible with dataWrT and ptrWrT
  localparam type ramWrT = struct packed {
    logic                valid;
    fifoTypesPkg::entryT addr;
    payloadT             payload;
  }
) (
  input  logic                clk,
  input  ramWrT               wr,
  input  fifoTypesPkg::ramRdT rd,
  output payloadT             rdData
);
  import fifoCfgPkg::*;

  payloadT mem [Depth];

  // A read and a write to the same entry on one edge return the old value
  always_ff @(posedge clk) begin
    if (wr.valid) begin
      mem[wr.addr] <= wr.payload;
    end
    if (rd.valid) begin
      rdData <= mem[rd.addr];
    end
  end

endmodule : sharedRam

//--- design/fifoTypesPkg.sv
// ----------------------------------------------------------------------
// Shared multi-FIFO types
// Packed structs that carry push requests and RAM accesses
// ----------------------------------------------------------------------

package fifoTypesPkg;

  typedef logic [fifoCfgPkg::FifoIdWidth-1:0] fifoIdT;
  typedef logic [fifoCfgPkg::AddrWidth-1:0] entryT;
  typedef logic [fifoCfgPkg::Width-1:0] dataT;

  // One push, steered to the logical FIFO named by fifoId
  typedef struct packed {
    fifoIdT fifoId;
    dataT   data;
  } pushReqT;

  // Data RAM write, field order matches the generic RAM write port
  typedef struct packed {
    logic  valid;
    entryT addr;
    dataT  data;
  } dataWrT;

  // Link write, next is the entry that follows addr in its list
  typedef struct packed {
    logic  valid;
    entryT addr;
    entryT next;
  } ptrWrT;

  typedef struct packed {
    logic  valid;
    entryT addr;
  } ramRdT;

endpackage : fifoTypesPkg

//--- design/fifoCfgPkg.sv
// ----------------------------------------------------------------------
// Shared multi-FIFO sizing
// Constants that size the shared storage and the logical FIFOs
// ----------------------------------------------------------------------

package fifoCfgPkg;

  // Four logical FIFOs share one storage pool
  localparam int NumFifos = 4;
  // Entries in the shared data RAM and the pointer RAM
  localparam int Depth = 16;
  // Payload bits per entry
  localparam int Width = 8;

  // Derived widths, kept explicit so that every port lines up
  localparam int FifoIdWidth = 2;
  localparam int AddrWidth = 4;
  // Counts 0 to Depth inclusive
  localparam int CountWidth = 5;

endpackage : fifoCfgPkg
